// ==== rtl/xbar_cfg_pkg.sv ====
// ----------------------------------------------------------------------
// Read crossbar configuration: port counts, widths, address rule type
// and the read response codes
// ----------------------------------------------------------------------
package xbar_cfg_pkg;

  localparam int unsigned NO_SLV_PORTS  = 2;
  localparam int unsigned NO_MST_PORTS  = 2;
  localparam int unsigned NO_ADDR_RULES = 2;

  localparam int unsigned ADDR_WIDTH   = 32;
  localparam int unsigned DATA_WIDTH   = 32;
  localparam int unsigned SLV_ID_WIDTH = 4;
  // Master side ID carries the source slave port index on top
  localparam int unsigned MST_ID_WIDTH = SLV_ID_WIDTH + $clog2(NO_SLV_PORTS);

  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [SLV_ID_WIDTH-1:0] slv_id_t;
  typedef logic [MST_ID_WIDTH-1:0] mst_id_t;

  typedef logic       mst_idx_t;
  // Master port index, or NO_MST_PORTS for the decode-error target
  typedef logic [1:0] sel_t;
  typedef logic       slv_idx_t;
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  typedef struct packed {
    mst_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } addr_rule_t;

endpackage

// ==== rtl/xbar_chan_pkg.sv ====
// ----------------------------------------------------------------------
// Read crossbar channel payloads for the AR and R channels, on the
// slave side and on the ID-extended master side
// ----------------------------------------------------------------------
package xbar_chan_pkg;

  import xbar_cfg_pkg::*;

  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
  } slv_ar_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
  } mst_ar_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
  } mst_r_t;

endpackage

// ==== rtl/addr_decoder.sv ====
// ----------------------------------------------------------------------
// Address decoder: matches an address against the rule table and
// falls back to the default port or the decode-error target
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module addr_decoder
  import xbar_cfg_pkg::*;
#(
  parameter int unsigned NO_ADDR_RULES = xbar_cfg_pkg::NO_ADDR_RULES
) (
  input  addr_t                          addr_i,
  input  addr_rule_t [NO_ADDR_RULES-1:0] addr_map_i,
  input  logic                           en_default_i,
  input  mst_idx_t                       default_port_i,
  output sel_t                           sel_o
);

  always_comb begin
    // No match yet
    if (en_default_i) begin
      sel_o = sel_t'(default_port_i);
    end else begin
      sel_o = sel_t'(NO_MST_PORTS);
    end
    // Later rules override earlier ones
    for (int unsigned r = 0; r < NO_ADDR_RULES; r++) begin
      if ((addr_i >= addr_map_i[r].start_addr) &&
          (addr_i < addr_map_i[r].end_addr)) begin
        sel_o = sel_t'(addr_map_i[r].idx);
      end
    end
  end

endmodule

// ==== rtl/trans_counter.sv ====
// ----------------------------------------------------------------------
// Outstanding read counter with full and empty flags
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module trans_counter #(
  parameter int unsigned MAX_TRANS = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic inc_i,
  input  logic dec_i,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned CNT_WIDTH = $clog2(MAX_TRANS + 1);

  logic [CNT_WIDTH-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (inc_i && !dec_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (dec_i && !inc_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign full_o  = (cnt_q == CNT_WIDTH'(MAX_TRANS));
  assign empty_o = (cnt_q == '0);

endmodule

// ==== rtl/rd_demux.sv ====
// ----------------------------------------------------------------------
// Read demux for one slave port: steers AR to one target, tracks the
// outstanding reads and returns R from the locked target
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rd_demux
  import xbar_cfg_pkg::*;
  import xbar_chan_pkg::*;
#(
  parameter int unsigned MAX_TRANS     = 4,
  parameter int unsigned NO_ADDR_RULES = xbar_cfg_pkg::NO_ADDR_RULES
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  slv_ar_t                        ar_i,
  input  logic                           ar_valid_i,
  output logic                           ar_ready_o,
  output slv_r_t                         r_o,
  output logic                           r_valid_o,
  input  logic                           r_ready_i,
  input  addr_rule_t [NO_ADDR_RULES-1:0] addr_map_i,
  input  logic                           en_default_i,
  input  mst_idx_t                       default_port_i,
  // Targets 0..NO_MST_PORTS-1 are master ports, the last one is the error slave
  output logic       [NO_MST_PORTS:0]    tgt_ar_valid_o,
  input  logic       [NO_MST_PORTS:0]    tgt_ar_ready_i,
  input  slv_r_t     [NO_MST_PORTS:0]    tgt_r_i,
  input  logic       [NO_MST_PORTS:0]    tgt_r_valid_i,
  output logic       [NO_MST_PORTS:0]    tgt_r_ready_o
);

  sel_t sel;
  sel_t locked_q;
  logic full, empty;
  logic stall;
  logic ar_hs, r_hs;

  addr_decoder #(
    .NO_ADDR_RULES ( NO_ADDR_RULES )
  ) u_addr_decoder (
    .addr_i         ( ar_i.addr      ),
    .addr_map_i     ( addr_map_i     ),
    .en_default_i   ( en_default_i   ),
    .default_port_i ( default_port_i ),
    .sel_o          ( sel            )
  );

  // All outstanding reads must share one target
  assign stall      = full || (!empty && (sel != locked_q));
  assign ar_ready_o = !stall && tgt_ar_ready_i[sel];
  assign ar_hs      = ar_valid_i && ar_ready_o;
  assign r_hs       = r_valid_o && r_ready_i;

  always_comb begin
    tgt_ar_valid_o      = '0;
    tgt_ar_valid_o[sel] = ar_valid_i && !stall;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      locked_q <= '0;
    end else if (ar_hs) begin
      locked_q <= sel;
    end
  end

  trans_counter #(
    .MAX_TRANS ( MAX_TRANS )
  ) u_trans_counter (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .inc_i   ( ar_hs   ),
    .dec_i   ( r_hs    ),
    .full_o  ( full    ),
    .empty_o ( empty   )
  );

  // Responses only come back from the locked target
  assign r_o       = tgt_r_i[locked_q];
  assign r_valid_o = tgt_r_valid_i[locked_q];

  always_comb begin
    tgt_r_ready_o           = '0;
    tgt_r_ready_o[locked_q] = r_ready_i;
  end

endmodule

// ==== rtl/decerr_slave.sv ====
// ----------------------------------------------------------------------
// Decode-error slave: answers each accepted read with DECERR
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module decerr_slave
  import xbar_cfg_pkg::*;
  import xbar_chan_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  slv_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output slv_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  logic    busy_q;
  slv_id_t id_q;

  // One read in flight at a time
  assign ar_ready_o = !busy_q;
  assign r_valid_o  = busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (ar_valid_i && ar_ready_o) begin
      busy_q <= 1'b1;
    end else if (r_valid_o && r_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      id_q <= ar_i.id;
    end
  end

  assign r_o = '{id: id_q, data: '0, resp: RESP_DECERR};

endmodule

// ==== rtl/ar_arb_fsm.sv ====
// ----------------------------------------------------------------------
// Round-robin AR arbiter that keeps its grant until the handshake
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ar_arb_fsm #(
  parameter int unsigned N_REQ     = 2,
  parameter int unsigned IDX_WIDTH = (N_REQ > 1) ? $clog2(N_REQ) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [N_REQ-1:0]     req_i,
  input  logic                 ack_i,
  output logic [IDX_WIDTH-1:0] gnt_o,
  output logic [N_REQ-1:0]     gnt_valid_o
);

  typedef enum logic {IDLE, LOCKED} state_e;

  state_e               state_q;
  logic [IDX_WIDTH-1:0] ptr_q, gnt_q, pick;
  logic                 found, gnt_act;

  // First requester after the last winner
  always_comb begin
    int unsigned cand;
    pick  = ptr_q;
    found = 1'b0;
    for (int unsigned k = 1; k <= N_REQ; k++) begin
      cand = (int'(ptr_q) + k) % N_REQ;
      if (!found && req_i[cand]) begin
        pick  = IDX_WIDTH'(cand);
        found = 1'b1;
      end
    end
  end

  assign gnt_o   = (state_q == LOCKED) ? gnt_q : pick;
  assign gnt_act = (state_q == LOCKED) ? req_i[gnt_q] : found;

  always_comb begin
    gnt_valid_o = '0;
    if (gnt_act) begin
      gnt_valid_o[gnt_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      ptr_q   <= '0;
      gnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (found && !ack_i) begin
            state_q <= LOCKED;
            gnt_q   <= pick;
          end
        end
        LOCKED: begin
          if (ack_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (ack_i) begin
        ptr_q <= gnt_o;
      end
    end
  end

endmodule

// ==== rtl/rd_mux.sv ====
// ----------------------------------------------------------------------
// Read mux for one master port: arbitrates AR with ID extension and
// returns R to the slave port named in the upper ID bits
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rd_mux
  import xbar_cfg_pkg::*;
  import xbar_chan_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  slv_ar_t [NO_SLV_PORTS-1:0]         slv_ar_i,
  input  logic    [NO_SLV_PORTS-1:0]         slv_ar_valid_i,
  output logic    [NO_SLV_PORTS-1:0]         slv_ar_ready_o,
  output slv_r_t  [NO_SLV_PORTS-1:0]         slv_r_o,
  output logic    [NO_SLV_PORTS-1:0]         slv_r_valid_o,
  input  logic    [NO_SLV_PORTS-1:0]         slv_r_ready_i,
  output mst_ar_t                            mst_ar_o,
  output logic                               mst_ar_valid_o,
  input  logic                               mst_ar_ready_i,
  input  mst_r_t                             mst_r_i,
  input  logic                               mst_r_valid_i,
  output logic                               mst_r_ready_o
);

  slv_idx_t                gnt;
  logic [NO_SLV_PORTS-1:0] gnt_valid;
  slv_idx_t                r_dst;

  ar_arb_fsm #(
    .N_REQ ( NO_SLV_PORTS )
  ) u_ar_arb_fsm (
    .clk_i       ( clk_i                            ),
    .rst_n_i     ( rst_n_i                          ),
    .req_i       ( slv_ar_valid_i                   ),
    .ack_i       ( mst_ar_valid_o && mst_ar_ready_i ),
    .gnt_o       ( gnt                              ),
    .gnt_valid_o ( gnt_valid                        )
  );

  // Source port index goes on top of the slave ID
  assign mst_ar_valid_o = |gnt_valid;
  assign mst_ar_o       = '{id: {gnt, slv_ar_i[gnt].id}, addr: slv_ar_i[gnt].addr};
  assign slv_ar_ready_o = gnt_valid & {NO_SLV_PORTS{mst_ar_ready_i}};

  assign r_dst         = slv_idx_t'(mst_r_i.id >> SLV_ID_WIDTH);
  assign mst_r_ready_o = slv_r_ready_i[r_dst];

  for (genvar k = 0; k < NO_SLV_PORTS; k++) begin : gen_r_split
    assign slv_r_o[k] = '{
      id:   mst_r_i.id[SLV_ID_WIDTH-1:0],
      data: mst_r_i.data,
      resp: mst_r_i.resp
    };
    assign slv_r_valid_o[k] = mst_r_valid_i && (r_dst == slv_idx_t'(k));
  end

endmodule

// ==== rtl/rd_xbar.sv ====
// ----------------------------------------------------------------------
// Read-only crossbar: per-port demuxes and error slaves on the slave
// side, per-port arbitrating muxes on the master side
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rd_xbar
  import xbar_cfg_pkg::*;
  import xbar_chan_pkg::*;
#(
  parameter int unsigned MAX_TRANS     = 4,
  parameter int unsigned NO_ADDR_RULES = xbar_cfg_pkg::NO_ADDR_RULES
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  slv_ar_t    [NO_SLV_PORTS-1:0]    slv_ar_i,
  input  logic       [NO_SLV_PORTS-1:0]    slv_ar_valid_i,
  output logic       [NO_SLV_PORTS-1:0]    slv_ar_ready_o,
  output slv_r_t     [NO_SLV_PORTS-1:0]    slv_r_o,
  output logic       [NO_SLV_PORTS-1:0]    slv_r_valid_o,
  input  logic       [NO_SLV_PORTS-1:0]    slv_r_ready_i,
  output mst_ar_t    [NO_MST_PORTS-1:0]    mst_ar_o,
  output logic       [NO_MST_PORTS-1:0]    mst_ar_valid_o,
  input  logic       [NO_MST_PORTS-1:0]    mst_ar_ready_i,
  input  mst_r_t     [NO_MST_PORTS-1:0]    mst_r_i,
  input  logic       [NO_MST_PORTS-1:0]    mst_r_valid_i,
  output logic       [NO_MST_PORTS-1:0]    mst_r_ready_o,
  input  addr_rule_t [NO_ADDR_RULES-1:0]   addr_map_i,
  input  logic       [NO_SLV_PORTS-1:0]    en_default_i,
  input  mst_idx_t   [NO_SLV_PORTS-1:0]    default_port_i
);

  // Demux side, one extra target per slave port for the error slave
  logic   [NO_SLV_PORTS-1:0][NO_MST_PORTS:0]   dmx_ar_valid, dmx_ar_ready;
  slv_r_t [NO_SLV_PORTS-1:0][NO_MST_PORTS:0]   dmx_r;
  logic   [NO_SLV_PORTS-1:0][NO_MST_PORTS:0]   dmx_r_valid, dmx_r_ready;
  // Mux side, indexed by master port first
  logic   [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0] mux_ar_valid, mux_ar_ready;
  slv_r_t [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0] mux_r;
  logic   [NO_MST_PORTS-1:0][NO_SLV_PORTS-1:0] mux_r_valid, mux_r_ready;

  for (genvar i = 0; i < NO_SLV_PORTS; i++) begin : gen_slv_port
    rd_demux #(
      .MAX_TRANS     ( MAX_TRANS     ),
      .NO_ADDR_RULES ( NO_ADDR_RULES )
    ) u_rd_demux (
      .clk_i          ( clk_i             ),
      .rst_n_i        ( rst_n_i           ),
      .ar_i           ( slv_ar_i[i]       ),
      .ar_valid_i     ( slv_ar_valid_i[i] ),
      .ar_ready_o     ( slv_ar_ready_o[i] ),
      .r_o            ( slv_r_o[i]        ),
      .r_valid_o      ( slv_r_valid_o[i]  ),
      .r_ready_i      ( slv_r_ready_i[i]  ),
      .addr_map_i     ( addr_map_i        ),
      .en_default_i   ( en_default_i[i]   ),
      .default_port_i ( default_port_i[i] ),
      .tgt_ar_valid_o ( dmx_ar_valid[i]   ),
      .tgt_ar_ready_i ( dmx_ar_ready[i]   ),
      .tgt_r_i        ( dmx_r[i]          ),
      .tgt_r_valid_i  ( dmx_r_valid[i]    ),
      .tgt_r_ready_o  ( dmx_r_ready[i]    )
    );

    decerr_slave u_decerr_slave (
      .clk_i      ( clk_i                          ),
      .rst_n_i    ( rst_n_i                        ),
      .ar_i       ( slv_ar_i[i]                    ),
      .ar_valid_i ( dmx_ar_valid[i][NO_MST_PORTS]  ),
      .ar_ready_o ( dmx_ar_ready[i][NO_MST_PORTS]  ),
      .r_o        ( dmx_r[i][NO_MST_PORTS]         ),
      .r_valid_o  ( dmx_r_valid[i][NO_MST_PORTS]   ),
      .r_ready_i  ( dmx_r_ready[i][NO_MST_PORTS]   )
    );

    for (genvar j = 0; j < NO_MST_PORTS; j++) begin : gen_cross
      assign mux_ar_valid[j][i] = dmx_ar_valid[i][j];
      assign dmx_ar_ready[i][j] = mux_ar_ready[j][i];
      assign dmx_r[i][j]        = mux_r[j][i];
      assign dmx_r_valid[i][j]  = mux_r_valid[j][i];
      assign mux_r_ready[j][i]  = dmx_r_ready[i][j];
    end
  end

  for (genvar j = 0; j < NO_MST_PORTS; j++) begin : gen_mst_port
    rd_mux u_rd_mux (
      .clk_i          ( clk_i             ),
      .rst_n_i        ( rst_n_i           ),
      .slv_ar_i       ( slv_ar_i          ),
      .slv_ar_valid_i ( mux_ar_valid[j]   ),
      .slv_ar_ready_o ( mux_ar_ready[j]   ),
      .slv_r_o        ( mux_r[j]          ),
      .slv_r_valid_o  ( mux_r_valid[j]    ),
      .slv_r_ready_i  ( mux_r_ready[j]    ),
      .mst_ar_o       ( mst_ar_o[j]       ),
      .mst_ar_valid_o ( mst_ar_valid_o[j] ),
      .mst_ar_ready_i ( mst_ar_ready_i[j] ),
      .mst_r_i        ( mst_r_i[j]        ),
      .mst_r_valid_i  ( mst_r_valid_i[j]  ),
      .mst_r_ready_o  ( mst_r_ready_o[j]  )
    );
  end

endmodule

// ==== tests/rd_xbar_props.sv ====
// ----------------------------------------------------------------------
// Bound checks on the read crossbar ports: routing, ID extension,
// handshake stability, decode errors, stalls and round-robin order
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module rd_xbar_props
  import xbar_cfg_pkg::*;
  import xbar_chan_pkg::*;
#(
  parameter int unsigned MAX_TRANS = 4
) (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input slv_ar_t  [NO_SLV_PORTS-1:0] slv_ar_i,
  input logic     [NO_SLV_PORTS-1:0] slv_ar_valid_i,
  input logic     [NO_SLV_PORTS-1:0] slv_ar_ready_o,
  input slv_r_t   [NO_SLV_PORTS-1:0] slv_r_o,
  input logic     [NO_SLV_PORTS-1:0] slv_r_valid_o,
  input logic     [NO_SLV_PORTS-1:0] slv_r_ready_i,
  input mst_ar_t  [NO_MST_PORTS-1:0] mst_ar_o,
  input logic     [NO_MST_PORTS-1:0] mst_ar_valid_o,
  input logic     [NO_MST_PORTS-1:0] mst_ar_ready_i,
  input mst_r_t   [NO_MST_PORTS-1:0] mst_r_i,
  input logic     [NO_MST_PORTS-1:0] mst_r_valid_i,
  input logic     [NO_MST_PORTS-1:0] mst_r_ready_o,
  input logic     [NO_SLV_PORTS-1:0] en_default_i,
  input mst_idx_t [NO_SLV_PORTS-1:0] default_port_i
);

  int unsigned                               err_cnt;
  sel_t [NO_SLV_PORTS-1:0]                   sel;
  logic [NO_SLV_PORTS-1:0]                   blocked;
  logic [NO_SLV_PORTS-1:0][NO_MST_PORTS-1:0] req_ok;

  // Port 0 owns 0x0000 to 0x0FFF and port 1 owns 0x1000 to 0x1FFF
  function automatic sel_t route(addr_t addr, logic en, mst_idx_t dflt);
    if (addr < 32'h1000) begin
      return 2'd0;
    end
    if (addr < 32'h2000) begin
      return 2'd1;
    end
    return en ? sel_t'(dflt) : sel_t'(NO_MST_PORTS);
  endfunction

  for (genvar i = 0; i < NO_SLV_PORTS; i++) begin : gen_slv
    int unsigned cnt_q;
    sel_t        tgt_q;
    logic        ar_hs, r_hs;

    assign sel[i]     = route(slv_ar_i[i].addr, en_default_i[i], default_port_i[i]);
    assign ar_hs      = slv_ar_valid_i[i] && slv_ar_ready_o[i];
    assign r_hs       = slv_r_valid_o[i] && slv_r_ready_i[i];
    assign blocked[i] = (cnt_q == MAX_TRANS) || ((cnt_q != 0) && (sel[i] != tgt_q));

    for (genvar j = 0; j < NO_MST_PORTS; j++) begin : gen_req
      assign req_ok[i][j] = slv_ar_valid_i[i] && !blocked[i] && (sel[i] == sel_t'(j));
    end

    // Reference count of outstanding reads and their shared target
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q <= 0;
        tgt_q <= '0;
      end else begin
        cnt_q <= cnt_q + ar_hs - r_hs;
        if (ar_hs) begin
          tgt_q <= sel[i];
        end
      end
    end

    a_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        blocked[i] |-> !slv_ar_ready_o[i])
      else begin
        err_cnt++;
        $error("CHECK FAILED slv_ar_ready_o[%0d] = 0x1 while stalled, expected 0x0", i);
      end

    a_decerr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ar_hs && (sel[i] == sel_t'(NO_MST_PORTS)) |=> slv_r_valid_o[i] &&
          (slv_r_o[i].resp == RESP_DECERR) && (slv_r_o[i].data == '0) &&
          (slv_r_o[i].id == $past(slv_ar_i[i].id)))
      else begin
        err_cnt++;
        $error("CHECK FAILED slv_r_o[%0d] = 0x%0h, valid 0x%0h, expected DECERR for id 0x%0h",
               i, slv_r_o[i], slv_r_valid_o[i], $past(slv_ar_i[i].id));
      end

    a_dflt_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        slv_ar_valid_i[i] && !slv_ar_ready_o[i] |=>
          $stable(en_default_i[i]) && $stable(default_port_i[i]))
      else begin
        err_cnt++;
        $error("Default port inputs of slave port %0d changed while an AR waited", i);
      end
  end

  for (genvar j = 0; j < NO_MST_PORTS; j++) begin : gen_mst
    slv_idx_t src;
    slv_idx_t dst;
    logic     hs;
    logic     owed_v_q;
    slv_idx_t owed_q;

    assign src = mst_ar_o[j].id[MST_ID_WIDTH-1];
    assign dst = mst_r_i[j].id[MST_ID_WIDTH-1];
    assign hs  = mst_ar_valid_o[j] && mst_ar_ready_i[j];

    // Port that must win the next grant here
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        owed_v_q <= 1'b0;
        owed_q   <= '0;
      end else if (hs) begin
        owed_v_q <= req_ok[~src][j];
        owed_q   <= ~src;
      end
    end

    a_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mst_ar_valid_o[j] |-> slv_ar_valid_i[src] && !blocked[src] &&
          (sel[src] == sel_t'(j)) && (mst_ar_o[j].addr == slv_ar_i[src].addr) &&
          (mst_ar_o[j].id[SLV_ID_WIDTH-1:0] == slv_ar_i[src].id))
      else begin
        err_cnt++;
        $error("CHECK FAILED mst_ar_o[%0d] = 0x%0h, slv_ar_i[%0d] = 0x%0h",
               j, mst_ar_o[j], src, slv_ar_i[src]);
      end

    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mst_ar_valid_o[j] && !mst_ar_ready_i[j] |=>
          mst_ar_valid_o[j] && $stable(mst_ar_o[j]))
      else begin
        err_cnt++;
        $error("CHECK FAILED mst_ar_o[%0d] = 0x%0h changed before ready, was 0x%0h",
               j, mst_ar_o[j], $past(mst_ar_o[j]));
      end

    // R back-pressure comes from the slave port named in the top ID bit
    a_r_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mst_r_valid_i[j] |-> (mst_r_ready_o[j] == slv_r_ready_i[dst]))
      else begin
        err_cnt++;
        $error("CHECK FAILED mst_r_ready_o[%0d] = 0x%0h, expected 0x%0h from slave port %0d",
               j, mst_r_ready_o[j], slv_r_ready_i[dst], dst);
      end

    a_fair: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hs && owed_v_q |-> (src == owed_q))
      else begin
        err_cnt++;
        $error("Master port %0d granted slave port %0d out of round-robin turn", j, src);
      end
  end

endmodule

// ==== tests/tb_rd_xbar.sv ====
// ----------------------------------------------------------------------
// Testbench for the read crossbar: two random read managers, two
// responding subordinates, response checks and the run verdict
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_rd_xbar
  import xbar_cfg_pkg::*;
  import xbar_chan_pkg::*;
();

  localparam int unsigned MAX_TRANS    = 4;
  localparam int unsigned N_READS      = 200;
  localparam int unsigned N_PER_PORT   = N_READS / NO_SLV_PORTS;
  localparam int unsigned LIMIT_CYCLES = N_READS * 50;
  localparam int unsigned RST_CYCLES   = 16;
  localparam data_t       DATA_KEY     = 32'h5a3c_96e1;

  logic                             clk_i;
  logic                             rst_n_i;
  slv_ar_t    [NO_SLV_PORTS-1:0]    slv_ar_i;
  logic       [NO_SLV_PORTS-1:0]    slv_ar_valid_i;
  logic       [NO_SLV_PORTS-1:0]    slv_ar_ready_o;
  slv_r_t     [NO_SLV_PORTS-1:0]    slv_r_o;
  logic       [NO_SLV_PORTS-1:0]    slv_r_valid_o;
  logic       [NO_SLV_PORTS-1:0]    slv_r_ready_i;
  mst_ar_t    [NO_MST_PORTS-1:0]    mst_ar_o;
  logic       [NO_MST_PORTS-1:0]    mst_ar_valid_o;
  logic       [NO_MST_PORTS-1:0]    mst_ar_ready_i;
  mst_r_t     [NO_MST_PORTS-1:0]    mst_r_i;
  logic       [NO_MST_PORTS-1:0]    mst_r_valid_i;
  logic       [NO_MST_PORTS-1:0]    mst_r_ready_o;
  addr_rule_t [NO_ADDR_RULES-1:0]   addr_map_i;
  logic       [NO_SLV_PORTS-1:0]    en_default_i;
  mst_idx_t   [NO_SLV_PORTS-1:0]    default_port_i;

  int unsigned fail_cnt;
  int unsigned rsp_cnt [NO_SLV_PORTS];

  rd_xbar #(
    .MAX_TRANS     ( MAX_TRANS     ),
    .NO_ADDR_RULES ( NO_ADDR_RULES )
  ) DUT (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_r_o        ( slv_r_o        ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_r_i        ( mst_r_i        ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  ),
    .addr_map_i     ( addr_map_i     ),
    .en_default_i   ( en_default_i   ),
    .default_port_i ( default_port_i )
  );

  bind rd_xbar rd_xbar_props #(.MAX_TRANS(MAX_TRANS)) u_props (.*);

  // Unmapped with no default gives DECERR, all else comes back from a subordinate
  function automatic slv_r_t expect_r(slv_ar_t ar, logic en);
    if ((ar.addr >= 32'h2000) && !en) begin
      return '{id: ar.id, data: '0, resp: RESP_DECERR};
    end
    return '{id: ar.id, data: ar.addr ^ DATA_KEY, resp: RESP_OKAY};
  endfunction

  // Regions 0 and 1 are mapped, 2 and 3 are not
  function automatic addr_t random_addr();
    addr_t base;
    base = addr_t'($urandom_range(3, 0)) << 12;
    return base | addr_t'($urandom & 32'hffc);
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    void'($urandom(32'hbf313481));
    fail_cnt       = 0;
    rst_n_i        = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = '0;
    slv_r_ready_i  = '0;
    mst_ar_ready_i = '0;
    mst_r_i        = '0;
    mst_r_valid_i  = '0;
    en_default_i   = '0;
    default_port_i = '0;
    addr_map_i[0]  = '{idx: 1'b0, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000};
    addr_map_i[1]  = '{idx: 1'b1, start_addr: 32'h0000_1000, end_addr: 32'h0000_2000};
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    wait (rsp_cnt[0] + rsp_cnt[1] == N_READS);
    repeat (4) @(posedge clk_i);
    if ((fail_cnt == 0) && (DUT.u_props.err_cnt == 0)) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "Read checks failed");
    end
  end

  // Stop at the first failed check, from here or from the bound checks
  initial begin
    wait ((fail_cnt != 0) || (DUT.u_props.err_cnt != 0));
    $display("Test FAILED");
    $fatal(1, "Stopped at the first failed check");
  end

  initial begin
    repeat (RST_CYCLES + LIMIT_CYCLES) @(posedge clk_i);
    $display("Timeout: not all %0d reads completed in %0d cycles", N_READS, LIMIT_CYCLES);
    $display("Test FAILED");
    $fatal(1, "Timeout");
  end

  for (genvar i = 0; i < NO_SLV_PORTS; i++) begin : gen_manager
    int unsigned sent;
    slv_r_t      exp_q[$];

    always @(posedge clk_i) begin
      slv_r_t want;
      if (rst_n_i) begin
        if (slv_ar_valid_i[i] && slv_ar_ready_o[i]) begin
          exp_q.push_back(expect_r(slv_ar_i[i], en_default_i[i]));
          slv_ar_valid_i[i] <= 1'b0;
        end
        if (slv_r_valid_o[i] && slv_r_ready_i[i]) begin
          if (exp_q.size() == 0) begin
            $display("Read response at slave port %0d with no read outstanding", i);
            fail_cnt++;
          end else begin
            want = exp_q.pop_front();
            assert (slv_r_o[i] == want) else begin
              $display("CHECK FAILED slv_r_o[%0d] = 0x%0h, expected 0x%0h", i, slv_r_o[i], want);
              fail_cnt++;
            end
            rsp_cnt[i]++;
          end
        end
        // New read, default settings only change while nothing waits
        if ((!slv_ar_valid_i[i] || slv_ar_ready_o[i]) && (sent < N_PER_PORT) &&
            ($urandom_range(1, 0) == 1)) begin
          slv_ar_i[i]       <= '{id: slv_id_t'($urandom), addr: random_addr()};
          slv_ar_valid_i[i] <= 1'b1;
          en_default_i[i]   <= 1'($urandom_range(1, 0));
          default_port_i[i] <= mst_idx_t'($urandom_range(1, 0));
          sent++;
        end
        slv_r_ready_i[i] <= ($urandom_range(3, 0) == 0);
      end
    end
  end

  for (genvar j = 0; j < NO_MST_PORTS; j++) begin : gen_subordinate
    mst_r_t rsp_q[$];

    always @(posedge clk_i) begin
      if (rst_n_i) begin
        if (mst_ar_valid_o[j] && mst_ar_ready_i[j]) begin
          rsp_q.push_back('{id: mst_ar_o[j].id, data: mst_ar_o[j].addr ^ DATA_KEY,
                            resp: RESP_OKAY});
        end
        if (mst_r_valid_i[j] && mst_r_ready_o[j]) begin
          mst_r_valid_i[j] <= 1'b0;
        end
        // Answers in order, with random gaps
        if ((!mst_r_valid_i[j] || mst_r_ready_o[j]) && (rsp_q.size() != 0) &&
            ($urandom_range(1, 0) == 1)) begin
          mst_r_i[j]       <= rsp_q.pop_front();
          mst_r_valid_i[j] <= 1'b1;
        end
        mst_ar_ready_i[j] <= ($urandom_range(2, 0) != 0);
      end
    end
  end

endmodule

// ==== list.f ====
rtl/xbar_cfg_pkg.sv
rtl/xbar_chan_pkg.sv
rtl/addr_decoder.sv
rtl/trans_counter.sv
rtl/rd_demux.sv
rtl/decerr_slave.sv
rtl/ar_arb_fsm.sv
rtl/rd_mux.sv
rtl/rd_xbar.sv
tests/rd_xbar_props.sv
tests/tb_rd_xbar.sv

// ==== Bender.yml ====
package:
  name: rd_xbar

sources:
  - files:
      - rtl/xbar_cfg_pkg.sv
      - rtl/xbar_chan_pkg.sv
      - rtl/addr_decoder.sv
      - rtl/trans_counter.sv
      - rtl/rd_demux.sv
      - rtl/decerr_slave.sv
      - rtl/ar_arb_fsm.sv
      - rtl/rd_mux.sv
      - rtl/rd_xbar.sv
  - target: test
    files:
      - tests/rd_xbar_props.sv
      - tests/tb_rd_xbar.sv
